/* rxcBusPkg.sv */
`default_nettype none

package rxcBusPkg;

    localparam int DATA_W      = 64;             // Beat width
    localparam int DW_PER_BEAT = DATA_W / 32;
    localparam int OFFSET_W    = $clog2(DW_PER_BEAT);

    // Completions carry a three dword header
    localparam int HDR_DW = 3;

    // First payload dword lands right after DW2 in beat 1
    localparam int START_OFFSET = HDR_DW % DW_PER_BEAT;

endpackage

`default_nettype wire

/* rxcTlpPkg.sv */
`default_nettype none

package rxcTlpPkg;

    // Header field widths
    localparam int FMT_W     = 3;
    localparam int TYPE_W    = 5;
    localparam int LEN_W     = 10;
    localparam int TAG_W     = 8;
    localparam int LOWADDR_W = 7;
    localparam int BYTECNT_W = 12;
    localparam int CPLID_W   = 16;
    localparam int STATUS_W  = 3;

    // DW0 sits in the low half of beat 0
    localparam int FMT_I  = 29;
    localparam int TYPE_I = 24;
    localparam int EP_I   = 14;       // Poisoned bit
    localparam int LEN_I  = 0;

    // DW1 sits in the high half of beat 0
    localparam int BYTECNT_I = 32;
    localparam int STATUS_I  = 45;
    localparam int CPLID_I   = 48;    // Completer ID in the top 16 bits

    // DW2 sits in the low half of beat 1
    localparam int LOWADDR_I = 0;
    localparam int TAG_I     = 8;

    // Cpl and CplD share one type code
    localparam logic [TYPE_W-1:0] TYPE_CPL = 5'b01010;

    // Bit inside the fmt field that marks a TLP with data
    localparam int FMT_PAYLOAD_BIT = 1;

endpackage

`default_nettype wire

/* rxcHeaderCapture.sv */
`timescale 1ns/1ps
`default_nettype none

module rxcHeaderCapture (
    input  wire                                CLK,
    input  wire                                rRST,
    input  wire  [rxcBusPkg::DATA_W-1:0]       rxData,
    input  wire                                rxValid,
    input  wire                                rxSop,
    output logic                               cplActive,
    output logic                               hdrHasData,
    output logic [rxcTlpPkg::LEN_W-1:0]        hdrLength,
    output logic [rxcTlpPkg::TAG_W-1:0]        metaTag,
    output logic [rxcTlpPkg::LOWADDR_W-1:0]    metaAddr,
    output logic [rxcTlpPkg::BYTECNT_W-1:0]    metaBytesRemaining,
    output logic [rxcTlpPkg::CPLID_W-1:0]      metaCompleterId,
    output logic [rxcTlpPkg::STATUS_W-1:0]     metaStatus,
    output logic                               metaEp,
    output logic                               hdrDw2Seen
);
    import rxcTlpPkg::*;

    logic [FMT_W-1:0]  fmt;
    logic [TYPE_W-1:0] tlpType;
    logic              startBeat;
    logic              dw2Beat;

    assign fmt       = rxData[FMT_I +: FMT_W];
    assign tlpType   = rxData[TYPE_I +: TYPE_W];
    assign startBeat = rxValid && rxSop;
    assign dw2Beat   = rxValid && !rxSop && !hdrDw2Seen;   // First beat after the start

    // Completion test and DW2 tracking
    always_ff @(posedge CLK) begin
        if (rRST) begin
            cplActive  <= 1'b0;
            hdrDw2Seen <= 1'b0;
        end else begin
            if (startBeat) begin
                cplActive  <= (tlpType == TYPE_CPL);
                hdrDw2Seen <= 1'b0;
            end else if (dw2Beat) begin
                hdrDw2Seen <= 1'b1;
            end
        end
    end

    // DW0 and DW1 fields from beat 0
    always_ff @(posedge CLK) begin
        if (startBeat) begin
            hdrHasData         <= fmt[FMT_PAYLOAD_BIT];
            hdrLength          <= rxData[LEN_I +: LEN_W];
            metaEp             <= rxData[EP_I];
            metaBytesRemaining <= rxData[BYTECNT_I +: BYTECNT_W];
            metaStatus         <= rxData[STATUS_I +: STATUS_W];
            metaCompleterId    <= rxData[CPLID_I +: CPLID_W];
        end
    end

    // DW2 fields from beat 1
    always_ff @(posedge CLK) begin
        if (dw2Beat) begin
            metaTag  <= rxData[TAG_I +: TAG_W];
            metaAddr <= rxData[LOWADDR_I +: LOWADDR_W];
        end
    end

endmodule

`default_nettype wire

/* rxcFraming.sv */
`timescale 1ns/1ps
`default_nettype none

module rxcFraming (
    input  wire                                  CLK,
    input  wire                                  rRST,
    input  wire  [rxcBusPkg::DATA_W-1:0]         rxData,
    input  wire                                  rxValid,
    input  wire                                  rxEop,
    input  wire                                  cplActive,
    input  wire                                  hdrHasData,
    input  wire  [rxcTlpPkg::LEN_W-1:0]          hdrLength,
    input  wire                                  hdrDw2Seen,
    output logic                                 frmValid,
    output logic [rxcBusPkg::DATA_W-1:0]         frmData,
    output logic                                 frmStart,
    output logic                                 frmEnd,
    output logic [rxcBusPkg::OFFSET_W-1:0]       frmEndOffset,
    output logic [rxcBusPkg::DW_PER_BEAT-1:0]    frmWordEnable
);
    import rxcBusPkg::*;
    import rxcTlpPkg::*;

    logic                   sopNext;      // Next accepted beat opens a new TLP
    logic                   accept;
    logic                   startBeat;
    logic [LEN_W-1:0]       lastDw;
    logic [OFFSET_W-1:0]    endOffset;
    logic [DW_PER_BEAT-1:0] startMask;
    logic [DW_PER_BEAT-1:0] endMask;

    // Beat 1 onwards of a completion
    assign accept    = rxValid && cplActive && !sopNext;
    assign startBeat = !hdrDw2Seen;       // DW2 not latched yet, so this is beat 1

    // Dword index of the last payload dword counted from DW0
    assign lastDw    = LEN_W'(HDR_DW - 1) + hdrLength;
    assign endOffset = lastDw[OFFSET_W-1:0];

    always_comb begin
        for (int i = 0; i < DW_PER_BEAT; i++) begin
            startMask[i] = !startBeat || (i >= START_OFFSET);   // Skip DW2 on beat 1
            endMask[i]   = !rxEop || (i <= endOffset);
        end
    end

    // Position tracking from the end flags
    always_ff @(posedge CLK) begin
        if (rRST) begin
            sopNext  <= 1'b1;
            frmValid <= 1'b0;
        end else begin
            if (rxValid) begin
                sopNext <= rxEop;
            end
            frmValid <= accept;
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            frmData       <= rxData;
            frmStart      <= startBeat;
            frmEnd        <= rxEop;
            frmEndOffset  <= endOffset;
            frmWordEnable <= hdrHasData ? (startMask & endMask) : '0;   // Cpl has no payload
        end
    end

endmodule

`default_nettype wire

/* rxcOutputStage.sv */
`timescale 1ns/1ps
`default_nettype none

module rxcOutputStage (
    input  wire                                  CLK,
    input  wire                                  rRST,
    input  wire                                  frmValid,
    input  wire  [rxcBusPkg::DATA_W-1:0]         frmData,
    input  wire                                  frmStart,
    input  wire                                  frmEnd,
    input  wire  [rxcBusPkg::OFFSET_W-1:0]       frmEndOffset,
    input  wire  [rxcBusPkg::DW_PER_BEAT-1:0]    frmWordEnable,
    input  wire  [rxcTlpPkg::LEN_W-1:0]          hdrLength,
    input  wire  [rxcTlpPkg::TAG_W-1:0]          metaTag,
    input  wire  [rxcTlpPkg::LOWADDR_W-1:0]      metaAddr,
    input  wire  [rxcTlpPkg::BYTECNT_W-1:0]      metaBytesRemaining,
    input  wire  [rxcTlpPkg::CPLID_W-1:0]        metaCompleterId,
    input  wire  [rxcTlpPkg::STATUS_W-1:0]       metaStatus,
    input  wire                                  metaEp,
    output logic                                 rxcValid,
    output logic [rxcBusPkg::DATA_W-1:0]         rxcData,
    output logic [rxcBusPkg::DW_PER_BEAT-1:0]    rxcWordEnable,
    output logic                                 rxcStartFlag,
    output logic [rxcBusPkg::OFFSET_W-1:0]       rxcStartOffset,
    output logic                                 rxcEndFlag,
    output logic [rxcBusPkg::OFFSET_W-1:0]       rxcEndOffset,
    output logic [rxcTlpPkg::LEN_W-1:0]          rxcMetaLength,
    output logic [rxcTlpPkg::TAG_W-1:0]          rxcMetaTag,
    output logic [rxcTlpPkg::LOWADDR_W-1:0]      rxcMetaAddr,
    output logic [rxcTlpPkg::BYTECNT_W-1:0]      rxcMetaBytesRemaining,
    output logic [rxcTlpPkg::CPLID_W-1:0]        rxcMetaCompleterId,
    output logic [rxcTlpPkg::STATUS_W-1:0]       rxcMetaStatus,
    output logic                                 rxcMetaEp
);
    import rxcBusPkg::*;

    assign rxcStartOffset = OFFSET_W'(START_OFFSET);   // Fixed for 3DW headers

    always_ff @(posedge CLK) begin
        if (rRST) begin
            rxcValid <= 1'b0;
        end else begin
            rxcValid <= frmValid;
        end
    end

    always_ff @(posedge CLK) begin
        if (frmValid) begin
            rxcData       <= frmData;
            rxcWordEnable <= frmWordEnable;
            rxcStartFlag  <= frmStart;
            rxcEndFlag    <= frmEnd;
            rxcEndOffset  <= frmEndOffset;
        end
    end

    // Metadata held for the whole completion
    always_ff @(posedge CLK) begin
        if (frmValid && frmStart) begin
            rxcMetaLength         <= hdrLength;
            rxcMetaTag            <= metaTag;
            rxcMetaAddr           <= metaAddr;
            rxcMetaBytesRemaining <= metaBytesRemaining;
            rxcMetaCompleterId    <= metaCompleterId;
            rxcMetaStatus         <= metaStatus;
            rxcMetaEp             <= metaEp;
        end
    end

endmodule

`default_nettype wire

/* rxcEngine.sv */
`timescale 1ns/1ps
`default_nettype none

module rxcEngine (
    input  wire                                  CLK,
    input  wire                                  rRST,
    input  wire  [rxcBusPkg::DATA_W-1:0]         rxData,
    input  wire                                  rxValid,
    input  wire                                  rxSop,
    input  wire                                  rxEop,
    output wire                                  rxcValid,
    output wire  [rxcBusPkg::DATA_W-1:0]         rxcData,
    output wire  [rxcBusPkg::DW_PER_BEAT-1:0]    rxcWordEnable,
    output wire                                  rxcStartFlag,
    output wire  [rxcBusPkg::OFFSET_W-1:0]       rxcStartOffset,
    output wire                                  rxcEndFlag,
    output wire  [rxcBusPkg::OFFSET_W-1:0]       rxcEndOffset,
    output wire  [rxcTlpPkg::LEN_W-1:0]          rxcMetaLength,
    output wire  [rxcTlpPkg::TAG_W-1:0]          rxcMetaTag,
    output wire  [rxcTlpPkg::LOWADDR_W-1:0]      rxcMetaAddr,
    output wire  [rxcTlpPkg::BYTECNT_W-1:0]      rxcMetaBytesRemaining,
    output wire  [rxcTlpPkg::CPLID_W-1:0]        rxcMetaCompleterId,
    output wire  [rxcTlpPkg::STATUS_W-1:0]       rxcMetaStatus,
    output wire                                  rxcMetaEp
);
    import rxcBusPkg::*;
    import rxcTlpPkg::*;

    // Header capture to framing and output
    wire                   cplActive;
    wire                   hdrHasData;
    wire [LEN_W-1:0]       hdrLength;
    wire                   hdrDw2Seen;
    wire [TAG_W-1:0]       metaTag;
    wire [LOWADDR_W-1:0]   metaAddr;
    wire [BYTECNT_W-1:0]   metaBytesRemaining;
    wire [CPLID_W-1:0]     metaCompleterId;
    wire [STATUS_W-1:0]    metaStatus;
    wire                   metaEp;

    // Framed beat
    wire                   frmValid;
    wire [DATA_W-1:0]      frmData;
    wire                   frmStart;
    wire                   frmEnd;
    wire [OFFSET_W-1:0]    frmEndOffset;
    wire [DW_PER_BEAT-1:0] frmWordEnable;

    rxcHeaderCapture u_rxcHeaderCapture (
        .CLK                (CLK),
        .rRST               (rRST),
        .rxData             (rxData),
        .rxValid            (rxValid),
        .rxSop              (rxSop),
        .cplActive          (cplActive),
        .hdrHasData         (hdrHasData),
        .hdrLength          (hdrLength),
        .metaTag            (metaTag),
        .metaAddr           (metaAddr),
        .metaBytesRemaining (metaBytesRemaining),
        .metaCompleterId    (metaCompleterId),
        .metaStatus         (metaStatus),
        .metaEp             (metaEp),
        .hdrDw2Seen         (hdrDw2Seen)
    );

    rxcFraming u_rxcFraming (
        .CLK           (CLK),
        .rRST          (rRST),
        .rxData        (rxData),
        .rxValid       (rxValid),
        .rxEop         (rxEop),
        .cplActive     (cplActive),
        .hdrHasData    (hdrHasData),
        .hdrLength     (hdrLength),
        .hdrDw2Seen    (hdrDw2Seen),
        .frmValid      (frmValid),
        .frmData       (frmData),
        .frmStart      (frmStart),
        .frmEnd        (frmEnd),
        .frmEndOffset  (frmEndOffset),
        .frmWordEnable (frmWordEnable)
    );

    rxcOutputStage u_rxcOutputStage (
        .CLK                   (CLK),
        .rRST                  (rRST),
        .frmValid              (frmValid),
        .frmData               (frmData),
        .frmStart              (frmStart),
        .frmEnd                (frmEnd),
        .frmEndOffset          (frmEndOffset),
        .frmWordEnable         (frmWordEnable),
        .hdrLength             (hdrLength),
        .metaTag               (metaTag),
        .metaAddr              (metaAddr),
        .metaBytesRemaining    (metaBytesRemaining),
        .metaCompleterId       (metaCompleterId),
        .metaStatus            (metaStatus),
        .metaEp                (metaEp),
        .rxcValid              (rxcValid),
        .rxcData               (rxcData),
        .rxcWordEnable         (rxcWordEnable),
        .rxcStartFlag          (rxcStartFlag),
        .rxcStartOffset        (rxcStartOffset),
        .rxcEndFlag            (rxcEndFlag),
        .rxcEndOffset          (rxcEndOffset),
        .rxcMetaLength         (rxcMetaLength),
        .rxcMetaTag            (rxcMetaTag),
        .rxcMetaAddr           (rxcMetaAddr),
        .rxcMetaBytesRemaining (rxcMetaBytesRemaining),
        .rxcMetaCompleterId    (rxcMetaCompleterId),
        .rxcMetaStatus         (rxcMetaStatus),
        .rxcMetaEp             (rxcMetaEp)
    );

endmodule

`default_nettype wire

/* tbRxcEngine.sv */
`timescale 1ns/1ps
`default_nettype none

module tbRxcEngine;
    import rxcBusPkg::*;
    import rxcTlpPkg::*;

    localparam int PERIOD      = 20;
    localparam int RST_CYCLES  = 8;
    localparam int IDLE_CYCLES = 10;
    localparam int NUM_RANDOM  = 20;
    localparam int TOTAL_TLPS  = 2 + 2 * NUM_RANDOM;    // Two fixed cases, then write and CplD pairs
    localparam int MAX_BEATS   = 10;                    // 3DW header plus 16 payload dwords
    localparam int WATCHDOG_CYCLES = RST_CYCLES + 2 * IDLE_CYCLES + 40 * TOTAL_TLPS;

    typedef struct packed {
        logic [DATA_W-1:0]      data;
        logic [DW_PER_BEAT-1:0] wordEnable;
        logic                   startFlag;
        logic                   endFlag;
        logic [OFFSET_W-1:0]    endOffset;
        logic [LEN_W-1:0]       len;
        logic [TAG_W-1:0]       tag;
        logic [LOWADDR_W-1:0]   addr;
        logic [BYTECNT_W-1:0]   bytes;
        logic [CPLID_W-1:0]     cplId;
        logic [STATUS_W-1:0]    status;
        logic                   ep;
    } expBeatT;

    logic                    CLK = 1'b0;
    logic                    rRST;
    logic [DATA_W-1:0]       rxData;
    logic                    rxValid;
    logic                    rxSop;
    logic                    rxEop;
    wire                     rxcValid;
    wire  [DATA_W-1:0]       rxcData;
    wire  [DW_PER_BEAT-1:0]  rxcWordEnable;
    wire                     rxcStartFlag;
    wire  [OFFSET_W-1:0]     rxcStartOffset;
    wire                     rxcEndFlag;
    wire  [OFFSET_W-1:0]     rxcEndOffset;
    wire  [LEN_W-1:0]        rxcMetaLength;
    wire  [TAG_W-1:0]        rxcMetaTag;
    wire  [LOWADDR_W-1:0]    rxcMetaAddr;
    wire  [BYTECNT_W-1:0]    rxcMetaBytesRemaining;
    wire  [CPLID_W-1:0]      rxcMetaCompleterId;
    wire  [STATUS_W-1:0]     rxcMetaStatus;
    wire                     rxcMetaEp;

    logic [DATA_W-1:0] tlpBeats [MAX_BEATS];
    int                tlpBeatCount;
    expBeatT           expQ[$];
    string             nameQ[$];
    int                dueQ[$];             // Cycle at which each beat must show up
    expBeatT           expBeat;
    string             expName;
    int                expDue;
    int                cycleCount = 0;
    bit                checkEnable = 1'b0;
    int                seed;

    rxcEngine u_rxcEngine (.*);

    always #(PERIOD / 2) CLK = ~CLK;

    always @(posedge CLK) cycleCount <= cycleCount + 1;

    task failRun;
        $display("Simulation failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic compareData(input string name, input logic [DATA_W-1:0] expValue,
                               input logic [DATA_W-1:0] actValue);
        if (actValue !== expValue) begin
            $display("Fail %s: expected %h, actual %h", name, expValue, actValue);
            failRun();
        end
    endtask

    task automatic compareEnable(input string name, input logic [DW_PER_BEAT-1:0] expValue,
                                 input logic [DW_PER_BEAT-1:0] actValue);
        if (actValue !== expValue) begin
            $display("Fail %s: expected %b, actual %b", name, expValue, actValue);
            failRun();
        end
    endtask

    // Sized for the widest metadata field
    task automatic compareField(input string name, input logic [CPLID_W-1:0] expValue,
                                input logic [CPLID_W-1:0] actValue);
        if (actValue !== expValue) begin
            $display("Fail %s: expected %h, actual %h", name, expValue, actValue);
            failRun();
        end
    endtask

    task automatic compareCycle(input string name, input int expValue, input int actValue);
        if (actValue != expValue) begin
            $display("Fail %s: expected cycle %0d, actual cycle %0d", name, expValue, actValue);
            failRun();
        end
    endtask

    function automatic expBeatT randomMeta(input int len);
        expBeatT m;
        m        = '0;
        m.len    = LEN_W'(len);
        m.tag    = TAG_W'($urandom);
        m.addr   = LOWADDR_W'($urandom);
        m.bytes  = BYTECNT_W'($urandom);
        m.cplId  = CPLID_W'($urandom);
        m.status = STATUS_W'($urandom);
        m.ep     = 1'($urandom_range(1));
        return m;
    endfunction

    // Header placed over random beats, so unused dwords carry junk
    function automatic void buildTlp(input logic [FMT_W-1:0] fmt,
                                     input logic [TYPE_W-1:0] tlpType, input expBeatT meta);
        int dwTotal;
        dwTotal      = 3 + (fmt[1] ? int'(meta.len) : 0);
        tlpBeatCount = (dwTotal + 1) / 2;
        for (int b = 0; b < MAX_BEATS; b++) begin
            tlpBeats[b] = {$urandom, $urandom};
        end
        tlpBeats[0][FMT_I +: FMT_W]         = fmt;
        tlpBeats[0][TYPE_I +: TYPE_W]       = tlpType;
        tlpBeats[0][EP_I]                   = meta.ep;
        tlpBeats[0][LEN_I +: LEN_W]         = meta.len;
        tlpBeats[0][BYTECNT_I +: BYTECNT_W] = meta.bytes;
        tlpBeats[0][STATUS_I +: STATUS_W]   = meta.status;
        tlpBeats[0][CPLID_I +: CPLID_W]     = meta.cplId;
        tlpBeats[1][TAG_I +: TAG_W]         = meta.tag;
        tlpBeats[1][LOWADDR_I +: LOWADDR_W] = meta.addr;
    endfunction

    // Reference model of the output beats of one completion
    function automatic void expectBeats(input string name, input bit hasData, input expBeatT meta);
        expBeatT e;
        int      dwTotal;
        int      lastBeat;
        int      g;
        dwTotal  = 3 + (hasData ? int'(meta.len) : 0);
        lastBeat = (dwTotal + 1) / 2 - 1;
        for (int b = 1; b <= lastBeat; b++) begin
            e           = meta;
            e.data      = tlpBeats[b];
            e.startFlag = (b == 1);
            e.endFlag   = (b == lastBeat);
            e.endOffset = OFFSET_W'((int'(meta.len) + 2) % 2);
            for (int i = 0; i < 2; i++) begin
                g = 2 * b + i;                  // Dword index counted from DW0
                e.wordEnable[i] = hasData && (g >= 3) && (g < 3 + int'(meta.len));
            end
            expQ.push_back(e);
            nameQ.push_back(name);
        end
    endfunction

    task automatic sendTlp(input bit isCpl, input bit useGaps);
        for (int b = 0; b < tlpBeatCount; b++) begin
            if (useGaps) begin
                repeat ($urandom_range(2)) begin
                    rxValid = 1'b0;
                    @(negedge CLK);
                end
            end
            rxValid = 1'b1;
            rxSop   = (b == 0);
            rxEop   = (b == tlpBeatCount - 1);
            rxData  = tlpBeats[b];
            if (isCpl && b > 0) begin
                dueQ.push_back(cycleCount + 2);   // Framing at the next edge, output one later
            end
            @(negedge CLK);
        end
        rxValid = 1'b0;
        rxSop   = 1'b0;
        rxEop   = 1'b0;
    endtask

    task automatic runCompletion(input string name, input bit hasData, input int len,
                                 input bit useGaps);
        expBeatT meta;
        meta = randomMeta(len);
        buildTlp(hasData ? 3'b010 : 3'b000, 5'b01010, meta);
        expectBeats(name, hasData, meta);
        sendTlp(1'b1, useGaps);
    endtask

    task automatic runWrite(input bit useGaps);
        buildTlp(3'b010, 5'b00000, randomMeta($urandom_range(8, 1)));   // MWr, 3DW header
        sendTlp(1'b0, useGaps);
    endtask

    always @(negedge CLK) begin
        if (checkEnable) begin
            if (rxcValid !== 1'b0 && rxcValid !== 1'b1) begin
                $display("rxcValid is unknown after reset");
                failRun();
            end else if (rxcValid) begin
                if (expQ.size() == 0 || dueQ.size() == 0) begin
                    $display("Unexpected output beat while no completion beat was pending");
                    failRun();
                end else begin
                    expBeat = expQ.pop_front();
                    expName = nameQ.pop_front();
                    expDue  = dueQ.pop_front();
                    compareCycle({expName, " latency"}, expDue, cycleCount);
                    compareData({expName, " data"}, expBeat.data, rxcData);
                    compareEnable({expName, " word enable"}, expBeat.wordEnable, rxcWordEnable);
                    compareField({expName, " start flag"}, expBeat.startFlag, rxcStartFlag);
                    compareField({expName, " end flag"}, expBeat.endFlag, rxcEndFlag);
                    compareField({expName, " end offset"}, expBeat.endOffset, rxcEndOffset);
                    if (expBeat.startFlag) begin
                        compareField({expName, " start offset"}, 1, rxcStartOffset);
                    end
                    compareField({expName, " length"}, expBeat.len, rxcMetaLength);
                    compareField({expName, " tag"}, expBeat.tag, rxcMetaTag);
                    compareField({expName, " lower address"}, expBeat.addr, rxcMetaAddr);
                    compareField({expName, " bytes remaining"}, expBeat.bytes,
                                 rxcMetaBytesRemaining);
                    compareField({expName, " completer ID"}, expBeat.cplId, rxcMetaCompleterId);
                    compareField({expName, " status"}, expBeat.status, rxcMetaStatus);
                    compareField({expName, " poisoned"}, expBeat.ep, rxcMetaEp);
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * PERIOD);
        $display("Timeout after %0d cycles, the expected beats did not all arrive",
                 WATCHDOG_CYCLES);
        failRun();
    end

    initial begin
        seed = 32'hb38a_da44;
        void'($urandom(seed));
        rRST    = 1'b1;
        rxData  = '0;
        rxValid = 1'b0;
        rxSop   = 1'b0;
        rxEop   = 1'b0;
        repeat (RST_CYCLES) @(negedge CLK);
        rRST        = 1'b0;
        checkEnable = 1'b1;
        repeat (IDLE_CYCLES) @(negedge CLK);    // Nothing sent, nothing may come out
        runCompletion("cplD len 1", 1'b1, 1, 1'b0);
        runCompletion("cpl no data", 1'b0, 0, 1'b0);
        for (int n = 0; n < NUM_RANDOM; n++) begin
            runWrite(1'b1);
            runCompletion($sformatf("cplD random %0d", n), 1'b1, $urandom_range(16, 2), 1'b1);
        end
        repeat (IDLE_CYCLES) @(negedge CLK);    // Last beat is out 2 cycles after it was sent
        if (expQ.size() == 0 && dueQ.size() == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("%0d expected beats never appeared", expQ.size());
            failRun();
        end
    end

endmodule

`default_nettype wire

/* project.f */
rxcBusPkg.sv
rxcTlpPkg.sv
rxcHeaderCapture.sv
rxcFraming.sv
rxcOutputStage.sv
rxcEngine.sv
tbRxcEngine.sv

/* Bender.yml */
package:
  name: rxc_engine

sources:
  - rxcBusPkg.sv
  - rxcTlpPkg.sv
  - rxcHeaderCapture.sv
  - rxcFraming.sv
  - rxcOutputStage.sv
  - rxcEngine.sv
  - target: test
    files:
      - tbRxcEngine.sv
